// File: logic/cache_pkg.sv
package cache_pkg;

    // two ways, the control FSM only knows hit_0 and hit_1
    localparam int num_ways = 2;

    // eight 32-bit words per line
    localparam int words_per_line = 8;

    // one CPU word
    typedef logic [31:0] word_t;

    // one cache line, word 0 in the low bits
    typedef logic [words_per_line-1:0][31:0] line_t;

    // byte address bits 31:5, also used as the stored tag
    typedef logic [26:0] line_addr_t;

    // CPU side request, read_write high for a write
    typedef struct packed {
        logic [31:0] address;
        word_t       wdata;
        logic        read_write;
    } cpu_req_t;

    // memory side request, one full line
    typedef struct packed {
        line_addr_t address;
        logic       read_write;
        line_t      wdata;
    } mem_req_t;

    // per-entry metadata
    typedef struct packed {
        logic       dirty;
        line_addr_t tag;
    } way_meta_t;

    // strobes from the miss FSM to the datapath
    typedef struct packed {
        logic cache_way_sel;
        logic data_source_sel;
        logic tag_bypass_sel;
        logic load;
        logic load_lru;
    } cache_ctrl_t;

    // lookup results gathered from all ways
    typedef struct packed {
        logic [num_ways-1:0]      hit;
        logic [num_ways-1:0]      dirty;
        way_meta_t [num_ways-1:0] meta;
    } way_status_t;

endpackage

// File: logic/cache_array.sv
module cache_array #(
    parameter type payload_t = logic,
    parameter int  num_sets  = 8
) (
    input  logic                        clk,
    input  logic [$clog2(num_sets)-1:0] index,
    input  logic                        write,
    input  payload_t                    wdata,
    output payload_t                    rdata
);

    // one entry per set
    payload_t entries [num_sets];

    // write on the clock edge
    always_ff @(posedge clk) begin
        if (write) begin
            entries[index] <= wdata;
        end
    end

    // read is combinational
    // lookup result is ready in the same cycle as the request
    assign rdata = entries[index];

endmodule

// File: logic/cache_way.sv
module cache_way #(
    parameter int num_sets = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [$clog2(num_sets)-1:0] index,
    input  cache_pkg::line_addr_t       lookup_tag,
    input  logic                        load,
    input  cache_pkg::line_t            wline,
    input  cache_pkg::way_meta_t        wmeta,
    output cache_pkg::line_t            rline,
    output cache_pkg::way_meta_t        meta,
    output logic                        hit,
    output logic                        dirty
);
    import cache_pkg::*;

    // one valid bit per set
    logic [num_sets-1:0] valid;

    // line storage
    cache_array #(
        .payload_t (line_t),
        .num_sets  (num_sets)
    ) u_data (
        .clk   (clk),
        .index (index),
        .write (load),
        .wdata (wline),
        .rdata (rline)
    );

    // tag and dirty storage
    cache_array #(
        .payload_t (way_meta_t),
        .num_sets  (num_sets)
    ) u_meta (
        .clk   (clk),
        .index (index),
        .write (load),
        .wdata (wmeta),
        .rdata (meta)
    );

    // any load makes the set valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (load) begin
            valid[index] <= 1'b1;
        end
    end

    // tag is the full line address
    assign hit   = valid[index] && (meta.tag == lookup_tag);
    assign dirty = valid[index] && meta.dirty;

endmodule

// File: logic/cache_write_steer.sv
module cache_write_steer (
    input  cache_pkg::cpu_req_t                              cpu_req,
    input  cache_pkg::cache_ctrl_t                           ctrl,
    input  cache_pkg::line_t                                 memory_rdata,
    input  cache_pkg::line_t [cache_pkg::num_ways-1:0]       rline,
    output logic [cache_pkg::num_ways-1:0]                   load,
    output cache_pkg::line_t                                 wline,
    output cache_pkg::way_meta_t                             wmeta
);
    import cache_pkg::*;

    // word offset inside the line
    logic [$clog2(words_per_line)-1:0] word_off;
    // current line with the CPU word patched in
    line_t merged;

    assign word_off = cpu_req.address[4:2];

    // read-modify-write of the selected way's line
    always_comb begin
        merged           = rline[ctrl.cache_way_sel];
        merged[word_off] = cpu_req.wdata;
    end

    // pick CPU merge or memory refill
    always_comb begin
        // tag is the CPU line address in both cases
        wmeta.tag = cpu_req.address[31:5];
        if (ctrl.data_source_sel) begin
            // refill, line matches memory
            wline       = memory_rdata;
            wmeta.dirty = 1'b0;
        end else begin
            // write hit, line now differs from memory
            wline       = merged;
            wmeta.dirty = 1'b1;
        end
    end

    // only the selected way sees the load
    always_comb begin
        load                     = '0;
        load[ctrl.cache_way_sel] = ctrl.load;
    end

endmodule

// File: logic/cache_read_select.sv
module cache_read_select #(
    parameter int num_sets = 8
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  cache_pkg::cpu_req_t                         cpu_req,
    input  cache_pkg::cache_ctrl_t                      ctrl,
    input  cache_pkg::way_status_t                      status,
    input  cache_pkg::line_t [cache_pkg::num_ways-1:0]  rline,
    output logic                                        hit_0,
    output logic                                        hit_1,
    output logic                                        dirty,
    output logic                                        lru,
    output cache_pkg::word_t                            cpu_rdata,
    output cache_pkg::mem_req_t                         mem_req
);
    import cache_pkg::*;

    localparam int index_w = $clog2(num_sets);

    // set index from the CPU address
    logic [index_w-1:0] index;
    // word offset inside the line
    logic [$clog2(words_per_line)-1:0] word_off;
    // one bit per set, names the way to evict next
    logic [num_sets-1:0] lru_bits;
    // the selected way's line
    line_t sel_line;

    assign index    = cpu_req.address[5 +: index_w];
    assign word_off = cpu_req.address[4:2];

    // on an access, point at the way not used
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (ctrl.load_lru) begin
            lru_bits[index] <= ~ctrl.cache_way_sel;
        end
    end

    assign lru   = lru_bits[index];
    assign hit_0 = status.hit[0];
    assign hit_1 = status.hit[1];

    // victim dirty decides write-back
    assign dirty = status.dirty[lru];

    // CPU read word
    assign sel_line  = rline[ctrl.cache_way_sel];
    assign cpu_rdata = sel_line[word_off];

    // memory side
    always_comb begin
        // stored tag for write-back, CPU address for refill
        if (ctrl.tag_bypass_sel) begin
            mem_req.address = cpu_req.address[31:5];
        end else begin
            mem_req.address = status.meta[lru].tag;
        end
        // direction comes from the FSM at top level
        mem_req.read_write = 1'b0;
        // write-back always sends the victim
        mem_req.wdata      = rline[lru];
    end

endmodule

// File: logic/cache_control.sv
module cache_control (
    // clock and reset
    input  logic                   clk,
    input  logic                   rst_n,

    // lookup results from the datapath
    input  logic                   hit_0,
    input  logic                   hit_1,
    input  logic                   dirty,
    input  logic                   lru,

    // CPU side
    input  logic                   cpu_request,
    input  logic                   cpu_read_write,

    // memory side
    input  logic                   memory_response,

    // strobes to the datapath
    output cache_pkg::cache_ctrl_t ctrl,

    // to the CPU
    output logic                   cpu_response,

    // to memory
    output logic                   memory_request,
    output logic                   memory_read_write
);

    typedef enum logic [2:0] {
        s_idle_hit,
        s_write_back,
        s_write_back_2,
        s_read_in,
        s_read_in_2
    } state_t;

    state_t state;
    state_t next_state;

    // any hit in either way
    logic hit;

    assign hit = hit_0 | hit_1;

    // outputs per state
    always_comb begin
        // defaults, all strobes idle
        ctrl              = '0;
        cpu_response      = 1'b0;
        memory_request    = 1'b0;
        memory_read_write = 1'b0;

        case (state)
            s_idle_hit: begin
                if (cpu_request && hit) begin
                    // way that hit
                    ctrl.cache_way_sel   = hit_1;
                    // mark the other way as lru
                    ctrl.load_lru        = 1'b1;
                    // CPU word merge
                    ctrl.data_source_sel = 1'b0;
                    // write only on a CPU write
                    ctrl.load            = cpu_read_write;
                    // same-cycle answer
                    cpu_response         = 1'b1;
                end
            end

            s_write_back: begin
                // victim way
                ctrl.cache_way_sel = lru;
                // address from the stored tag
                ctrl.tag_bypass_sel = 1'b0;
                // line write to memory
                memory_request     = 1'b1;
                memory_read_write  = 1'b1;
            end

            s_write_back_2: begin
                // request dropped, wait for response to fall
                ctrl.cache_way_sel = lru;
            end

            s_read_in: begin
                // refill the victim way
                ctrl.cache_way_sel   = lru;
                // address from the CPU request
                ctrl.tag_bypass_sel  = 1'b1;
                // line from memory
                ctrl.data_source_sel = 1'b1;
                // held high so the response edge latches the data
                ctrl.load            = 1'b1;
                // line read from memory
                memory_request       = 1'b1;
                memory_read_write    = 1'b0;
            end

            s_read_in_2: begin
                // nothing driven, handshake closing
                ctrl.cache_way_sel = lru;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

    // transitions
    always_comb begin
        next_state = state;

        case (state)
            s_idle_hit: begin
                // miss, clean victim goes straight to refill
                if (cpu_request && !hit) begin
                    if (dirty) begin
                        next_state = s_write_back;
                    end else begin
                        next_state = s_read_in;
                    end
                end
            end

            s_write_back: begin
                if (memory_response) begin
                    next_state = s_write_back_2;
                end
            end

            s_write_back_2: begin
                if (!memory_response) begin
                    next_state = s_read_in;
                end
            end

            s_read_in: begin
                if (memory_response) begin
                    next_state = s_read_in_2;
                end
            end

            s_read_in_2: begin
                // back to idle, the request then hits
                if (!memory_response) begin
                    next_state = s_idle_hit;
                end
            end

            default: begin
                next_state = s_idle_hit;
            end
        endcase
    end

    // state register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle_hit;
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: logic/cache_top.sv
module cache_top #(
    parameter int num_sets = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cpu_request,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                memory_response,
    input  cache_pkg::line_t    memory_rdata,
    output logic                cpu_response,
    output cache_pkg::word_t    cpu_rdata,
    output logic                memory_request,
    output cache_pkg::mem_req_t mem_req
);
    import cache_pkg::*;

    // FSM to datapath
    cache_ctrl_t ctrl;
    logic        hit_0;
    logic        hit_1;
    logic        dirty;
    logic        lru;
    logic        memory_read_write;

    // per-way signals
    logic [num_ways-1:0]      way_load;
    logic [num_ways-1:0]      way_hit;
    logic [num_ways-1:0]      way_dirty;
    way_meta_t [num_ways-1:0] way_meta;
    line_t [num_ways-1:0]     way_rline;

    // shared write data
    line_t     wline;
    way_meta_t wmeta;

    way_status_t status;
    mem_req_t    sel_mem_req;
    logic [$clog2(num_sets)-1:0] index;

    assign index  = cpu_req.address[5 +: $clog2(num_sets)];
    assign status = '{hit: way_hit, dirty: way_dirty, meta: way_meta};

    cache_control u_control (
        .clk, .rst_n, .hit_0, .hit_1, .dirty, .lru, .cpu_request,
        .cpu_read_write (cpu_req.read_write),
        .memory_response, .ctrl, .cpu_response, .memory_request, .memory_read_write
    );

    cache_write_steer u_steer (
        .cpu_req, .ctrl, .memory_rdata, .rline (way_rline),
        .load (way_load), .wline, .wmeta
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_way #(.num_sets(num_sets)) u_way (
            .clk, .rst_n, .index,
            .lookup_tag (cpu_req.address[31:5]),
            .load       (way_load[w]),
            .wline, .wmeta,
            .rline      (way_rline[w]),
            .meta       (way_meta[w]),
            .hit        (way_hit[w]),
            .dirty      (way_dirty[w])
        );
    end

    cache_read_select #(.num_sets(num_sets)) u_select (
        .clk, .rst_n, .cpu_req, .ctrl, .status, .rline (way_rline),
        .hit_0, .hit_1, .dirty, .lru, .cpu_rdata, .mem_req (sel_mem_req)
    );

    // direction from the FSM, address and data from the select
    always_comb begin
        mem_req            = sel_mem_req;
        mem_req.read_write = memory_read_write;
    end

endmodule

// File: testbench/cache_memory_model.sv
module cache_memory_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                memory_request,
    input  cache_pkg::mem_req_t mem_req,
    output logic                memory_response,
    output cache_pkg::line_t    memory_rdata
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    // only lines written back are stored, the rest come from the fill pattern
    line_t lines [line_addr_t];
    integer seed;
    int delay;
    mem_req_t req;

    // every word depends on the full line address and the word index
    function automatic line_t fill_line(input line_addr_t la);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w] = {2'b10, la, w[2:0]};
        end
        return l;
    endfunction

    initial begin
        seed            = 32'h7e800dd5;
        memory_response = 1'b0;
        memory_rdata    = '0;
        forever begin
            // request level is stable at the falling edge
            @(negedge clk);
            if (rst_n && memory_request) begin
                req   = mem_req;
                // 1 to 6 cycles of latency
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(posedge clk);
                #2;
                if (req.read_write) begin
                    lines[req.address] = req.wdata;
                end else if (lines.exists(req.address)) begin
                    memory_rdata = lines[req.address];
                end else begin
                    memory_rdata = fill_line(req.address);
                end
                memory_response = 1'b1;
                // response held until the request falls
                do begin
                    @(negedge clk);
                end while (memory_request);
                @(posedge clk);
                #2;
                memory_response = 1'b0;
            end
        end
    end

endmodule

// File: testbench/cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int num_sets     = 8;
    localparam int num_random   = 200;
    localparam int num_directed = 20;
    // 6-cycle memory delay times 4 handshake phases times 40 ns clock plus margin
    localparam int watchdog_ns  = (num_random + num_directed) * 6 * 4 * 40 + 20000;

    logic     clk;
    logic     rst_n;
    logic     cpu_request;
    cpu_req_t cpu_req;
    logic     cpu_response;
    word_t    cpu_rdata;
    logic     memory_request;
    mem_req_t mem_req;
    logic     memory_response;
    line_t    memory_rdata;

    // golden memory indexed by word address
    word_t golden [logic [29:0]];
    // memory requests seen as {read_write, line address}
    logic [27:0] traffic [$];
    logic   req_seen;
    word_t  exp_rdata;
    line_t  exp_wline;
    string  cur_test;
    int     data_errors;
    int     traffic_errors;
    int     protocol_errors;
    integer seed;

    cache_top #(.num_sets(num_sets)) UUT (.*);

    cache_memory_model u_memory (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // fill pattern word tagged by line address and word index
    function automatic word_t pattern_word(input line_addr_t la, input logic [2:0] w);
        return {2'b10, la, w};
    endfunction

    function automatic word_t golden_word(input logic [31:0] addr);
        if (golden.exists(addr[31:2])) begin
            return golden[addr[31:2]];
        end
        return pattern_word(addr[31:5], addr[4:2]);
    endfunction

    function automatic line_t golden_line(input line_addr_t la);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w] = golden_word({la, w[2:0], 2'b00});
        end
        return l;
    endfunction

    // byte address from tag and set index and word offset for 8 sets
    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return {tag[23:0], set[2:0], word[2:0], 2'b00};
    endfunction

    // log each new memory request and the line expected on a write-back
    always @(negedge clk) begin
        if (rst_n && memory_request && !req_seen) begin
            traffic.push_back({mem_req.read_write, mem_req.address});
        end
        if (rst_n && memory_request) begin
            exp_wline = golden_line(mem_req.address);
        end
        req_seen = memory_request;
    end

    reset_quiet: assert property (@(posedge clk)
        (!rst_n || $past(!rst_n)) |-> (!cpu_response && !memory_request))
    else begin
        protocol_errors++;
        $display("** Error [reset] response/request expected 0/0 actual %b/%b",
                 $sampled(cpu_response), $sampled(memory_request));
    end

    read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_response && !cpu_req.read_write) |-> (cpu_rdata == exp_rdata))
    else begin
        data_errors++;
        $display("** Error [%s] cpu_rdata expected %h actual %h",
                 cur_test, $sampled(exp_rdata), $sampled(cpu_rdata));
    end

    refill_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (memory_request && !mem_req.read_write) |-> (mem_req.address == cpu_req.address[31:5]))
    else begin
        traffic_errors++;
        $display("** Error [%s] refill address expected %h actual %h",
                 cur_test, $sampled(cpu_req.address[31:5]), $sampled(mem_req.address));
    end

    writeback_data: assert property (@(posedge clk) disable iff (!rst_n)
        (memory_request && mem_req.read_write) |-> (mem_req.wdata == exp_wline))
    else begin
        data_errors++;
        $display("** Error [%s] write-back line expected %h actual %h",
                 cur_test, $sampled(exp_wline), $sampled(mem_req.wdata));
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            traffic_errors++;
            $display("** Error [%s] %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_traffic(input int exp_rd, input int exp_wr);
        int rd;
        int wr;
        rd = 0;
        wr = 0;
        foreach (traffic[i]) begin
            if (traffic[i][27]) begin
                wr++;
            end else begin
                rd++;
            end
        end
        check_value("memory reads", exp_rd, rd);
        check_value("memory writes", exp_wr, wr);
    endtask

    // one CPU request starting 2 ns after a rising edge
    task automatic cpu_access(input string name, input logic wr, input logic [31:0] addr,
                              input word_t data);
        cur_test    = name;
        exp_rdata   = golden_word(addr);
        cpu_req     = '{address: addr, wdata: data, read_write: wr};
        cpu_request = 1'b1;
        do begin
            @(negedge clk);
        end while (!cpu_response);
        // golden follows the write at its response
        if (wr) begin
            golden[addr[31:2]] = data;
        end
        @(posedge clk);
        #2;
        cpu_request = 1'b0;
    endtask

    initial begin
        int    tag;
        int    set;
        int    word;
        word_t data;
        seed            = 32'h7e800dd5;
        rst_n           = 1'b0;
        // a request held through reset must not be answered
        cpu_req         = '{address: make_addr(1, 0, 3), wdata: '0, read_write: 1'b0};
        cpu_request     = 1'b1;
        req_seen        = 1'b0;
        exp_rdata       = '0;
        exp_wline       = '0;
        cur_test        = "reset";
        data_errors     = 0;
        traffic_errors  = 0;
        protocol_errors = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // first access after reset misses
        cpu_access("read_miss", 1'b0, make_addr(1, 0, 3), '0);
        check_traffic(1, 0);
        if (traffic.size() > 0) begin
            check_value("read line address", make_addr(1, 0, 3) >> 5, traffic[0][26:0]);
        end
        traffic.delete();
        cpu_access("read_hit", 1'b0, make_addr(1, 0, 3), '0);
        check_traffic(0, 0);

        // write hit then readback with the neighbour word untouched
        cpu_access("write_hit", 1'b1, make_addr(1, 0, 3), 32'hcafe_0001);
        cpu_access("write_readback", 1'b0, make_addr(1, 0, 3), '0);
        cpu_access("write_neighbor", 1'b0, make_addr(1, 0, 4), '0);
        check_traffic(0, 0);

        // A dirty in set 1 then B then C evicts A
        cpu_access("evict_write_a", 1'b1, make_addr(2, 1, 5), 32'h0bad_f00d);
        cpu_access("evict_read_b", 1'b0, make_addr(3, 1, 0), '0);
        traffic.delete();
        cpu_access("evict_read_c", 1'b0, make_addr(4, 1, 0), '0);
        check_traffic(1, 1);
        if (traffic.size() == 2) begin
            check_value("first request is write", 1, traffic[0][27]);
            check_value("write-back address", make_addr(2, 1, 0) >> 5, traffic[0][26:0]);
            check_value("second request is read", 0, traffic[1][27]);
        end

        // A and B in set 2 and A touched so C must replace B
        cpu_access("lru_a", 1'b0, make_addr(5, 2, 0), '0);
        cpu_access("lru_b", 1'b0, make_addr(6, 2, 0), '0);
        cpu_access("lru_touch_a", 1'b0, make_addr(5, 2, 1), '0);
        traffic.delete();
        cpu_access("lru_c", 1'b0, make_addr(7, 2, 0), '0);
        check_traffic(1, 0);
        traffic.delete();
        cpu_access("lru_keep_a", 1'b0, make_addr(5, 2, 2), '0);
        check_traffic(0, 0);
        traffic.delete();
        cpu_access("lru_lost_b", 1'b0, make_addr(6, 2, 0), '0);
        check_traffic(1, 0);

        // random mix over 4 sets by 3 tags so ways get evicted
        for (int i = 0; i < num_random; i++) begin
            tag  = 8 + ($unsigned($random(seed)) % 3);
            set  = 4 + ($unsigned($random(seed)) % 4);
            word = $unsigned($random(seed)) % 8;
            data = $random(seed);
            cpu_access("random", data[0], make_addr(tag, set, word), $random(seed));
        end
        repeat (2) @(posedge clk);

        $display("errors: data %0d, traffic %0d, protocol %0d",
                 data_errors, traffic_errors, protocol_errors);
        if (data_errors + traffic_errors + protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: cache_subsys.f
logic/cache_pkg.sv
logic/cache_array.sv
logic/cache_way.sv
logic/cache_write_steer.sv
logic/cache_read_select.sv
logic/cache_control.sv
logic/cache_top.sv
testbench/cache_memory_model.sv
testbench/cache_tb.sv
